// File: hw/nes_mem_pkg.sv
//**********************************************************************
// shared constants and types of the NES memory bridge
// imported by every bridge module and by the testbench
//**********************************************************************
`default_nettype none

package nes_mem_pkg;

    localparam int ADDR_W      = 22;    // byte address into the 4 MB map
    localparam int WORD_AW     = 16;    // backend word address bits, higher bits alias
    localparam int TEST_WORDS  = 8;     // self-test length in words
    localparam int TEST_IDX_W  = $clog2(TEST_WORDS);
    localparam int INIT_CYCLES = 16;    // backend init stand-in
    localparam int APB_AW      = 5;     // one bit past 0xc so the 0x10 hole is reachable

    // memory map, PRG ROM starts at 0
    localparam logic [ADDR_W-1:0] PRG_ROM_END  = 22'h1f_ffff;
    localparam logic [ADDR_W-1:0] CHR_ROM_END  = 22'h37_ffff;
    localparam logic [ADDR_W-1:0] INT_RAM_BASE = 22'h38_0000;
    localparam logic [ADDR_W-1:0] INT_RAM_END  = 22'h38_07ff;
    localparam logic [ADDR_W-1:0] PRG_RAM_BASE = 22'h3c_0000;
    localparam logic [ADDR_W-1:0] PRG_RAM_END  = 22'h3d_ffff;
    localparam logic [ADDR_W-1:0] TEST_BASE    = 22'h38_0000;   // self-test window

    // apb register offsets
    localparam logic [APB_AW-1:0] REG_STATUS   = 5'h0;   // busy, fails, test/init done
    localparam logic [APB_AW-1:0] REG_WRITTEN  = 5'h4;
    localparam logic [APB_AW-1:0] REG_UNMAPPED = 5'h8;
    localparam logic [APB_AW-1:0] REG_CTRL     = 5'hc;   // bit 0 starts a retest

    typedef enum logic [1:0] {NOP, READ, WRITE, REFRESH} mem_op_t;

    typedef enum logic [2:0] {PRG_ROM, CHR_ROM, INT_RAM, PRG_RAM, UNMAPPED} region_t;

    typedef enum logic [2:0] {
        S_INIT, S_TEST_WR, S_TEST_RD, S_NORMAL, S_WAIT
    } seq_state_t;

    // decode to execute
    typedef struct packed {
        mem_op_t           op;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
        logic              to_a;      // read lands on dout_a
        logic              to_b;
    } mem_req_t;

    // execute to result
    typedef struct packed {
        logic        done;            // one cycle per request
        logic [15:0] rdata;
        logic        was_a;
        logic        was_b;
        logic        unmapped;        // no memory access took place
        logic        was_write;
    } mem_rsp_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

// File: hw/mem_req_decode.sv
//**********************************************************************
// decode stage, takes one core request while the bridge is idle
// registers it with its op and memory region for the sequencer
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_req_decode (
    input  wire                               clk,
    input  wire                               resetn,
    input  wire                               read_a,
    input  wire                               read_b,
    input  wire                               write,
    input  wire                               refresh,
    input  wire [nes_mem_pkg::ADDR_W-1:0]     addr,
    input  wire [7:0]                         din,
    input  wire                               accept_ok,   // sequencer idle
    output logic                              accepted,    // request taken this edge
    output nes_mem_pkg::mem_req_t             req,
    output nes_mem_pkg::region_t              region
);
    import nes_mem_pkg::*;

    logic    any_req;
    mem_op_t op_sel;
    region_t region_sel;

    assign any_req  = read_a | read_b | write | refresh;
    assign accepted = accept_ok & any_req;      // busy rises on this same edge

    // refresh beats write beats read
    always_comb begin
        if (refresh)
            op_sel = REFRESH;
        else if (write)
            op_sel = WRITE;
        else if (read_a | read_b)
            op_sel = READ;
        else
            op_sel = NOP;
    end

    always_comb begin
        if (addr <= PRG_ROM_END)
            region_sel = PRG_ROM;
        else if (addr <= CHR_ROM_END)
            region_sel = CHR_ROM;
        else if ((addr >= INT_RAM_BASE) && (addr <= INT_RAM_END))
            region_sel = INT_RAM;
        else if ((addr >= PRG_RAM_BASE) && (addr <= PRG_RAM_END))
            region_sel = PRG_RAM;
        else
            region_sel = UNMAPPED;      // holes between the windows
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req    <= '0;
            region <= PRG_ROM;
        end else if (accepted) begin
            req.op    <= op_sel;
            req.addr  <= addr;
            req.wdata <= din;
            req.to_a  <= read_a & (op_sel == READ);   // both ports may read together
            req.to_b  <= read_b & (op_sel == READ);
            region    <= region_sel;
        end else begin
            req.op <= NOP;      // op lives one cycle, the rest is held for the sequencer
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_sequencer.sv
//**********************************************************************
// execute stage, waits for backend init, runs the read/write self-test
// then issues one backend operation per decoded request
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer (
    input  wire                               clk,
    input  wire                               resetn,
    input  wire nes_mem_pkg::mem_req_t        req,
    input  wire nes_mem_pkg::region_t         region,
    input  wire                               retest,
    output logic                              accept_ok,
    output logic                              mem_rd,
    output logic                              mem_wr,
    output logic                              mem_refresh,
    output logic [nes_mem_pkg::WORD_AW-1:0]   mem_addr,
    output logic [15:0]                       mem_wdata,
    input  wire [15:0]                        mem_rdata,
    input  wire                               mem_data_ready,
    input  wire                               mem_busy,
    output nes_mem_pkg::mem_rsp_t             rsp,
    output logic                              init_done,
    output logic                              test_done,
    output logic                              fail_low,
    output logic                              fail_high
);
    import nes_mem_pkg::*;

    seq_state_t            state;
    logic [TEST_IDX_W-1:0] idx;             // self-test word
    logic                  retest_pend;
    mem_op_t               cur_op;
    logic                  cur_unmapped;
    logic [7:0]            pat;             // expected low byte, high byte is its complement
    logic                  op_end;
    logic                  last_idx;

    assign pat      = 8'(idx) ^ 8'ha5;
    assign last_idx = (idx == TEST_IDX_W'(TEST_WORDS - 1));
    // closed while a request or its completion is in flight
    assign accept_ok = (state == S_NORMAL) & (req.op == NOP) & ~rsp.done & ~retest_pend;
    // reads end on data_ready, the others when the backend drops busy
    assign op_end = cur_unmapped | ((cur_op == READ) ? mem_data_ready : ~mem_busy);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= S_INIT;
            idx          <= '0;
            retest_pend  <= 1'b0;
            cur_op       <= NOP;
            cur_unmapped <= 1'b0;
            mem_rd       <= 1'b0;
            mem_wr       <= 1'b0;
            mem_refresh  <= 1'b0;
            rsp          <= '0;
            init_done    <= 1'b0;
            test_done    <= 1'b0;
            fail_low     <= 1'b0;
            fail_high    <= 1'b0;
        end else begin
            mem_rd      <= 1'b0;        // strobes are single cycle
            mem_wr      <= 1'b0;
            mem_refresh <= 1'b0;
            rsp.done    <= 1'b0;
            case (state)
                S_INIT: if (!mem_busy) begin
                    init_done <= 1'b1;
                    state     <= S_TEST_WR;
                end
                S_TEST_WR: if (!mem_busy) begin
                    mem_wr    <= 1'b1;
                    mem_addr  <= TEST_BASE[WORD_AW-1:0] + WORD_AW'(idx);
                    mem_wdata <= {~pat, pat};
                    idx       <= idx + 1'b1;          // wraps to 0 for the read pass
                    if (last_idx)
                        state <= S_TEST_RD;
                end
                S_TEST_RD: if (mem_data_ready) begin
                    if (mem_rdata[7:0] != pat)
                        fail_low <= 1'b1;
                    if (mem_rdata[15:8] != ~pat)
                        fail_high <= 1'b1;
                    idx <= idx + 1'b1;
                    if (last_idx) begin
                        state     <= S_NORMAL;
                        test_done <= ~retest_pend;
                        rsp       <= mem_rsp_t'{done: 1'b1, default: '0};   // lets busy fall
                    end
                end else if (!mem_busy) begin
                    mem_rd   <= 1'b1;
                    mem_addr <= TEST_BASE[WORD_AW-1:0] + WORD_AW'(idx);
                end
                S_NORMAL: if (req.op != NOP) begin
                    cur_op       <= req.op;
                    cur_unmapped <= (region == UNMAPPED) & (req.op != REFRESH);
                    mem_rd       <= (req.op == READ) & (region != UNMAPPED);
                    mem_wr       <= (req.op == WRITE) & (region != UNMAPPED);
                    mem_refresh  <= (req.op == REFRESH);
                    mem_addr     <= req.addr[WORD_AW-1:0];   // aliases on the low bits
                    mem_wdata    <= {req.wdata, req.wdata};  // byte on both lanes
                    state        <= S_WAIT;
                end else if (retest_pend) begin
                    retest_pend <= 1'b0;
                    fail_low    <= 1'b0;
                    fail_high   <= 1'b0;
                    idx         <= '0;
                    state       <= S_TEST_WR;
                end
                S_WAIT: if (op_end) begin
                    rsp.done      <= 1'b1;
                    rsp.rdata     <= mem_rdata;
                    rsp.was_a     <= req.to_a;
                    rsp.was_b     <= req.to_b;
                    rsp.unmapped  <= cur_unmapped;
                    rsp.was_write <= (cur_op == WRITE);
                    state         <= S_NORMAL;
                end
                default: state <= S_INIT;
            endcase
            // retest waits for the current op, busy stays up from here on
            if (retest) begin
                retest_pend <= 1'b1;
                test_done   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_backend.sv
//**********************************************************************
// behavioural 16-bit word memory standing in for the DDR3 controller
// one op at a time, latency of 2 to 5 cycles from a free-running LFSR
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_backend (
    input  wire                               clk,
    input  wire                               resetn,
    input  wire                               rd,
    input  wire                               wr,
    input  wire                               refresh,
    input  wire [nes_mem_pkg::WORD_AW-1:0]    addr,
    input  wire [15:0]                        wdata,
    output logic [15:0]                       rdata,
    output logic                              data_ready,
    output logic                              busy
);
    import nes_mem_pkg::*;

    logic [15:0]        mem [2**WORD_AW];
    logic [4:0]         init_cnt;      // init stand-in countdown
    logic [7:0]         lfsr;
    logic [1:0]         lat;           // cycles left of the current op
    logic               op_busy;
    logic               op_rd;
    logic [WORD_AW-1:0] addr_q;
    logic               start;

    assign start = (rd | wr | refresh) & ~op_busy & (init_cnt == '0);
    // strobe cycle already counts as busy
    assign busy  = (init_cnt != '0) | op_busy | rd | wr | refresh;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            init_cnt   <= 5'(INIT_CYCLES);
            lfsr       <= 8'h01;
            lat        <= '0;
            op_busy    <= 1'b0;
            op_rd      <= 1'b0;
            data_ready <= 1'b0;
        end else begin
            lfsr       <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            data_ready <= 1'b0;
            if (init_cnt != '0)
                init_cnt <= init_cnt - 1'b1;
            if (start) begin
                op_busy <= 1'b1;
                op_rd   <= rd;
                lat     <= lfsr[1:0];              // plus 2 for strobe and finish
            end else if (op_busy) begin
                if (lat == '0) begin
                    op_busy    <= 1'b0;
                    data_ready <= op_rd;           // pulse with rdata
                end else begin
                    lat <= lat - 1'b1;
                end
            end
        end
    end

    // array and data path
    always_ff @(posedge clk) begin
        if (start & wr)
            mem[addr] <= wdata;
        if (start)
            addr_q <= addr;
        if (op_busy & (lat == '0) & op_rd)
            rdata <= mem[addr_q];
    end

endmodule

`default_nettype wire

// File: hw/mem_result.sv
//**********************************************************************
// result stage, steers read data to dout_a/dout_b and owns core busy
// also keeps the mapped write and unmapped access counters
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_result (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          accepted,      // from decode
    input  wire nes_mem_pkg::mem_rsp_t   rsp,
    input  wire                          test_done,
    output logic [7:0]                   dout_a,
    output logic [7:0]                   dout_b,
    output logic                         busy,
    output logic [19:0]                  total_written,
    output logic [15:0]                  unmapped_count
);
    logic [7:0] rd_byte;

    assign rd_byte = rsp.unmapped ? 8'hff : rsp.rdata[7:0];   // holes read as 0xff

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy           <= 1'b1;        // held through init and self-test
            total_written  <= '0;
            unmapped_count <= '0;
        end else begin
            busy <= accepted | ~test_done | (busy & ~rsp.done);
            if (rsp.done & rsp.was_write & ~rsp.unmapped)
                total_written <= total_written + 1'b1;
            if (rsp.done & rsp.unmapped)
                unmapped_count <= unmapped_count + 1'b1;
        end
    end

    // only the flagged ports change
    always_ff @(posedge clk) begin
        if (rsp.done & rsp.was_a)
            dout_a <= rd_byte;
        if (rsp.done & rsp.was_b)
            dout_b <= rd_byte;
    end

endmodule

`default_nettype wire

// File: hw/mem_apb_regs.sv
//**********************************************************************
// APB3 register block without wait states, status, counters, retest
// read data comes straight from the status inputs in the access phase
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_apb_regs (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire nes_mem_pkg::apb_req_t   apb,
    output logic [31:0]                  prdata,
    output logic                         pslverr,
    input  wire                          init_done,
    input  wire                          test_done,
    input  wire                          fail_low,
    input  wire                          fail_high,
    input  wire                          busy,
    input  wire [19:0]                   total_written,
    input  wire [15:0]                   unmapped_count,
    output logic                         retest        // one-cycle pulse
);
    import nes_mem_pkg::*;

    logic access;
    logic known;                 // offset decodes to a register

    assign access = apb.psel & apb.penable;

    always_comb begin
        known = 1'b1;
        case (apb.paddr)
            REG_STATUS:   prdata = {27'd0, busy, fail_high, fail_low, test_done, init_done};
            REG_WRITTEN:  prdata = {12'd0, total_written};
            REG_UNMAPPED: prdata = {16'd0, unmapped_count};
            REG_CTRL:     prdata = 32'd0;     // write only, reads as zero
            default: begin
                prdata = 32'd0;
                known  = 1'b0;
            end
        endcase
    end

    // bad offset, or a write to one of the read-only registers
    assign pslverr = access & (~known | (apb.pwrite & (apb.paddr != REG_CTRL)));

    always_ff @(posedge clk) begin
        if (!resetn)
            retest <= 1'b0;
        else
            retest <= access & apb.pwrite & (apb.paddr == REG_CTRL) & apb.pwdata[0];
    end

endmodule

`default_nettype wire

// File: hw/nes_mem_top.sv
//**********************************************************************
// NES memory bridge top, decode -> sequencer -> backend -> result
// plus the APB register block for status and retest
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module nes_mem_top (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             read_a,
    input  wire                             read_b,
    input  wire                             write,
    input  wire                             refresh,
    input  wire [nes_mem_pkg::ADDR_W-1:0]   addr,
    input  wire [7:0]                       din,
    output wire [7:0]                       dout_a,
    output wire [7:0]                       dout_b,
    output wire                             busy,
    output wire [19:0]                      total_written,
    output wire                             fail_low,
    output wire                             fail_high,
    input  wire nes_mem_pkg::apb_req_t      apb,
    output wire [31:0]                      prdata,
    output wire                             pslverr
);
    import nes_mem_pkg::*;

    mem_req_t           req;
    region_t            region;
    mem_rsp_t           rsp;
    logic               accept_ok;
    logic               accepted;
    logic               mem_rd;
    logic               mem_wr;
    logic               mem_refresh;
    logic [WORD_AW-1:0] mem_addr;
    logic [15:0]        mem_wdata;
    logic [15:0]        mem_rdata;
    logic               mem_data_ready;
    logic               mem_busy;
    logic               init_done;
    logic               test_done;
    logic               retest;
    logic [15:0]        unmapped_count;

    mem_req_decode u_decode (
        .clk, .resetn, .read_a, .read_b, .write, .refresh, .addr, .din,
        .accept_ok, .accepted, .req, .region
    );

    mem_sequencer u_seq (
        .clk, .resetn, .req, .region, .retest, .accept_ok,
        .mem_rd, .mem_wr, .mem_refresh, .mem_addr, .mem_wdata,
        .mem_rdata, .mem_data_ready, .mem_busy,
        .rsp, .init_done, .test_done, .fail_low, .fail_high
    );

    mem_backend u_backend (
        .clk, .resetn, .rd(mem_rd), .wr(mem_wr), .refresh(mem_refresh),
        .addr(mem_addr), .wdata(mem_wdata),
        .rdata(mem_rdata), .data_ready(mem_data_ready), .busy(mem_busy)
    );

    mem_result u_result (
        .clk, .resetn, .accepted, .rsp, .test_done,
        .dout_a, .dout_b, .busy, .total_written, .unmapped_count
    );

    mem_apb_regs u_apb (
        .clk, .resetn, .apb, .prdata, .pslverr,
        .init_done, .test_done, .fail_low, .fail_high, .busy,
        .total_written, .unmapped_count, .retest
    );

endmodule

`default_nettype wire

// File: include/tb_check.svh
//**********************************************************************
// value check and pass/fail tallies, included inside the testbench
// module body, the summary line reads pass_count and fail_count
//**********************************************************************
`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

int pass_count = 0;
int fail_count = 0;

// compares up to 32 bits, x or z on got counts as a mismatch
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
        fail_count++;
        $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end else begin
        pass_count++;
    end
endtask

`endif

// File: verification/tb_nes_mem.sv
//**********************************************************************
// testbench for the NES memory bridge, random byte traffic against an
// associative-array model, unmapped holes, APB status and retest
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_nes_mem;
    import nes_mem_pkg::*;

    localparam int WAIT_LIMIT = 200;    // cycles allowed per wait on busy
    localparam int POOL_SIZE  = 48;     // mapped addresses used by the traffic
    localparam int RAND_OPS   = 300;

    logic        clk = 1'b0;
    logic        resetn;
    logic        read_a;
    logic        read_b;
    logic        write;
    logic        refresh;
    logic [21:0] addr;
    logic [7:0]  din;
    apb_req_t    apb;
    logic [7:0]  dout_a;
    logic [7:0]  dout_b;
    logic        busy;
    logic [19:0] total_written;
    logic        fail_low;
    logic        fail_high;
    logic [31:0] prdata;
    logic        pslverr;

    logic [7:0]  model [int];           // expected byte per byte address
    logic [21:0] pool [POOL_SIZE];
    bit          used_low [int];        // low 16 bits taken, keeps words apart
    int          writes_expected = 0;
    int          unmapped_expected = 0; // accesses that fell into a hole
    logic [7:0]  exp_a;
    logic [7:0]  exp_b;
    bit          a_valid = 1'b0;        // port holds a known value
    bit          b_valid = 1'b0;

    `include "tb_check.svh"

    nes_mem_top uut (
        .clk, .resetn, .read_a, .read_b, .write, .refresh, .addr, .din,
        .dout_a, .dout_b, .busy, .total_written, .fail_low, .fail_high,
        .apb, .prdata, .pslverr
    );

    always #4 clk = ~clk;

    // the four windows of the map, everything else is a hole
    function automatic bit is_mapped(input logic [21:0] a);
        return (a <= 22'h37_ffff) ||
               ((a >= 22'h38_0000) && (a <= 22'h38_07ff)) ||
               ((a >= 22'h3c_0000) && (a <= 22'h3d_ffff));
    endfunction

    function automatic logic [21:0] random_mapped_addr();
        logic [21:0] a;
        case ($urandom % 4)
            0:       a = 22'($urandom % 32'h20_0000);                // PRG ROM
            1:       a = 22'h20_0000 + 22'($urandom % 32'h18_0000);  // CHR ROM
            2:       a = 22'h38_0000 + 22'($urandom % 32'h800);      // internal RAM
            default: a = 22'h3c_0000 + 22'($urandom % 32'h2_0000);   // PRG RAM
        endcase
        return a;
    endfunction

    // distinct low 16 bits, none inside the self-test words 0..7
    task automatic build_pool();
        logic [21:0] a;
        for (int i = 0; i < POOL_SIZE; i++) begin
            do
                a = random_mapped_addr();
            while ((a[15:0] < 16'd8) || used_low.exists(int'(a[15:0])));
            used_low[int'(a[15:0])] = 1'b1;
            pool[i] = a;
        end
    endtask

    task automatic print_counts();
        $display("checks: %0d ok, %0d bad", pass_count, fail_count);
    endtask

    // sampled on falling edges, clear of the rising-edge updates
    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((busy !== level) && (cycles < WAIT_LIMIT)) begin
            cycles++;
            @(negedge clk);
        end
        if (busy !== level) begin
            fail_count++;
            $display("ERROR at %0t: busy never went to %0d within %0d cycles during %s",
                     $time, level, WAIT_LIMIT, what);
            print_counts();
            $display("Testbench failed");
            $finish;
        end
    endtask

    // one-cycle request pulse, accepted on the edge that drops it
    task automatic issue(input logic ra, input logic rb, input logic wr, input logic rf,
                         input logic [21:0] a, input logic [7:0] d);
        @(posedge clk);
        read_a  <= ra;
        read_b  <= rb;
        write   <= wr;
        refresh <= rf;
        addr    <= a;
        din     <= d;
        @(posedge clk);
        read_a  <= 1'b0;
        read_b  <= 1'b0;
        write   <= 1'b0;
        refresh <= 1'b0;
        wait_busy(1'b0, "request completion");
    endtask

    task automatic write_byte(input logic [21:0] a, input logic [7:0] d);
        issue(1'b0, 1'b0, 1'b1, 1'b0, a, d);
        if (is_mapped(a)) begin           // holes drop the write
            model[int'(a)] = d;
            writes_expected++;
        end else begin
            unmapped_expected++;
        end
    endtask

    task automatic read_byte(input logic [21:0] a, input logic use_a, input logic use_b);
        logic [7:0] exp;
        exp = is_mapped(a) ? model[int'(a)] : 8'hff;
        if (!is_mapped(a))
            unmapped_expected++;
        issue(use_a, use_b, 1'b0, 1'b0, a, 8'h00);
        if (use_a) begin
            exp_a   = exp;
            a_valid = 1'b1;
        end
        if (use_b) begin
            exp_b   = exp;
            b_valid = 1'b1;
        end
        if (a_valid)
            check_value("dout_a", dout_a, exp_a);   // unflagged port must hold
        if (b_valid)
            check_value("dout_b", dout_b, exp_b);
    endtask

    task automatic apb_access(input logic wr, input logic [4:0] offs, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb.psel    <= 1'b1;          // setup phase
        apb.penable <= 1'b0;
        apb.pwrite  <= wr;
        apb.paddr   <= offs;
        apb.pwdata  <= wdata;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;               // zero wait states, valid in access phase
        err   = pslverr;
        @(posedge clk);
        apb.psel    <= 1'b0;
        apb.penable <= 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] offs, input string name, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, offs, 32'd0, rd, err);
        check_value(name, rd, exp);
        check_value({name, " pslverr"}, err, 1'b0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %0d errors", name, fail_count - errs_before);
    endtask

    initial begin
        int          seed;
        int          errs;
        int          port;
        logic [21:0] a;
        logic [31:0] rd;
        logic        err;

        seed    = $urandom(75878);
        resetn  = 1'b0;
        read_a  = 1'b0;
        read_b  = 1'b0;
        write   = 1'b0;
        refresh = 1'b0;
        addr    = '0;
        din     = '0;
        apb     = '0;
        build_pool();

        // 1: reset values, then init wait and self-test
        errs = fail_count;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value("busy in reset", busy, 1'b1);
        check_value("fail_low in reset", fail_low, 1'b0);
        check_value("fail_high in reset", fail_high, 1'b0);
        check_value("total_written in reset", total_written, 0);
        @(posedge clk);
        resetn <= 1'b1;
        wait_busy(1'b0, "self-test after reset");
        check_value("fail_low", fail_low, 1'b0);
        check_value("fail_high", fail_high, 1'b0);
        read_reg(REG_STATUS, "REG_STATUS", 32'h3);          // init_done and test_done
        read_reg(REG_UNMAPPED, "REG_UNMAPPED", 32'd0);
        report_test("1 reset and self-test", errs);

        // 2: random traffic, reads only where the model has a byte
        errs = fail_count;
        for (int i = 0; i < RAND_OPS; i++) begin
            a = pool[$urandom % POOL_SIZE];
            if (!model.exists(int'(a)) || (($urandom % 2) == 0)) begin
                write_byte(a, 8'($urandom));
            end else begin
                port = $urandom % 2;
                read_byte(a, port == 0, port == 1);
            end
        end
        for (int i = 0; i < POOL_SIZE; i++)     // sweep everything written
            if (model.exists(int'(pool[i])))
                read_byte(pool[i], (i % 2) == 0, (i % 2) == 1);
        report_test("2 random traffic", errs);

        // 3: dual-port read, request during busy, refresh over write
        errs = fail_count;
        write_byte(pool[0], 8'($urandom));
        write_byte(pool[1], ~model[int'(pool[0])]);   // dout_a must visibly change below
        read_byte(pool[0], 1'b1, 1'b1);
        a = pool[1];
        @(posedge clk);
        read_a <= 1'b1;
        addr   <= a;
        @(posedge clk);                          // read taken here
        read_a <= 1'b0;
        write  <= 1'b1;                          // raised while busy, must be ignored
        addr   <= pool[0];
        din    <= ~model[int'(pool[0])];
        @(posedge clk);
        write  <= 1'b0;
        wait_busy(1'b0, "read with a blocked write");
        exp_a = model[int'(a)];
        check_value("dout_a", dout_a, exp_a);
        check_value("total_written", total_written, writes_expected);
        read_byte(pool[0], 1'b1, 1'b0);
        issue(1'b0, 1'b0, 1'b1, 1'b1, a, ~model[int'(a)]);  // refresh wins
        check_value("total_written", total_written, writes_expected);
        read_byte(a, 1'b0, 1'b1);
        report_test("3 dual read and busy", errs);

        // 4: holes, aliased onto pool words so a leaked write shows up
        errs = fail_count;
        for (int k = 0; k < 8; k++)
            if (!model.exists(int'(pool[k])))
                write_byte(pool[k], 8'($urandom));
        for (int k = 0; k < 8; k++) begin
            a = ((k % 4) < 2) ? (22'h3e_0000 | 22'(pool[k][15:0]))
                              : (22'h39_0000 | 22'(pool[k][15:0]));
            if ((k % 2) == 0) begin
                write_byte(a, ~model[int'(pool[k])]);
            end else begin
                port = $urandom % 2;
                read_byte(a, port == 0, port == 1);
            end
            read_reg(REG_UNMAPPED, "REG_UNMAPPED", unmapped_expected);
        end
        for (int k = 0; k < 8; k++)
            read_byte(pool[k], 1'b1, 1'b0);
        report_test("4 unmapped holes", errs);

        // 5: write counter, retest, bad APB offset
        errs = fail_count;
        read_reg(REG_WRITTEN, "REG_WRITTEN", writes_expected);
        check_value("total_written", total_written, writes_expected);
        apb_access(1'b1, REG_CTRL, 32'd1, rd, err);
        check_value("REG_CTRL pslverr", err, 1'b0);
        wait_busy(1'b1, "retest start");
        wait_busy(1'b0, "retest self-test");
        check_value("fail_low", fail_low, 1'b0);
        check_value("fail_high", fail_high, 1'b0);
        read_reg(REG_STATUS, "REG_STATUS", 32'h3);
        read_reg(REG_WRITTEN, "REG_WRITTEN", writes_expected);
        apb_access(1'b0, 5'h10, 32'd0, rd, err);
        check_value("pslverr read 0x10", err, 1'b1);
        apb_access(1'b1, 5'h10, 32'd0, rd, err);
        check_value("pslverr write 0x10", err, 1'b1);
        apb_access(1'b1, REG_WRITTEN, 32'd0, rd, err);   // read-only register
        check_value("pslverr write REG_WRITTEN", err, 1'b1);
        read_byte(pool[0], 1'b0, 1'b1);                  // outside the test window
        report_test("5 counters and retest", errs);

        print_counts();
        if (fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hw/nes_mem_pkg.sv
hw/mem_req_decode.sv
hw/mem_sequencer.sv
hw/mem_backend.sv
hw/mem_result.sv
hw/mem_apb_regs.sv
hw/nes_mem_top.sv
verification/tb_nes_mem.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run, pass or fail decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_nes_mem -f project.f -o tb_nes_mem \
    && ./obj_dir/tb_nes_mem > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
